// ==== filelist.f ====
+incdir+tb
rtl/romload_pkg.sv
rtl/spi_cmd_rx.sv
rtl/dl_fifo.sv
rtl/ioctl_writer.sv
rtl/romload_top.sv
tb/tb_romload.sv

// ==== rtl/dl_fifo.sv ====
// **********************************************************
// circular FIFO of download items between SPI and writer
// pushes while full are lost and latch the overflow flag
// **********************************************************

`timescale 1ns/10ps

module dl_fifo #(
   parameter int FIFO_DEPTH = 8     // power of two
) (
   input  logic                  clk_sys,
   input  logic                  rst_i,
   input  logic                  push_i,
   input  romload_pkg::dl_item_t push_item_i,
   input  logic                  pop_i,
   output romload_pkg::dl_item_t pop_item_o,
   output logic                  empty_o,
   output logic                  overflow_o
);

   localparam int PW = $clog2(FIFO_DEPTH);

   romload_pkg::dl_item_t mem_q [FIFO_DEPTH];

   // extra msb tells full from empty
   logic [PW:0] wr_ptr_q;
   logic [PW:0] rd_ptr_q;
   logic        full_w;
   logic        wr_en_w;
   logic        rd_en_w;

   assign empty_o = (wr_ptr_q == rd_ptr_q);
   assign full_w  = (wr_ptr_q[PW] != rd_ptr_q[PW]) &&
                    (wr_ptr_q[PW-1:0] == rd_ptr_q[PW-1:0]);
   assign wr_en_w = push_i & ~full_w;
   assign rd_en_w = pop_i & ~empty_o;

   assign pop_item_o = mem_q[rd_ptr_q[PW-1:0]];   // show-ahead

   always_ff @(posedge clk_sys) begin
      if (wr_en_w) begin
         mem_q[wr_ptr_q[PW-1:0]] <= push_item_i;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (wr_en_w) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en_w) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // sticky until the next download starts
         if (push_i && full_w) begin
            overflow_o <= 1'b1;
         end else if (wr_en_w && push_item_i.kind == romload_pkg::KIND_START) begin
            overflow_o <= 1'b0;
         end
      end
   end

endmodule

// ==== rtl/ioctl_writer.sv ====
// **********************************************************
// drains the download FIFO into the memory write port
// four-phase req/ack per byte, owns address and busy flag
// **********************************************************

`timescale 1ns/10ps

module ioctl_writer #(
   parameter int AW = 22
) (
   input  logic                  clk_sys,
   input  logic                  rst_i,
   input  logic                  empty_i,
   input  romload_pkg::dl_item_t pop_item_i,
   input  logic                  ioctl_ack_i,
   output logic                  pop_o,
   output logic [AW-1:0]         ioctl_addr_o,
   output logic [7:0]            ioctl_data_o,
   output logic                  ioctl_req_o,
   output logic                  downloading_o
);

   romload_pkg::wr_state_e state_q;

   // items are only taken between writes
   assign pop_o = (state_q == romload_pkg::WR_IDLE) & ~empty_i;

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         state_q       <= romload_pkg::WR_IDLE;
         ioctl_req_o   <= 1'b0;
         ioctl_addr_o  <= '0;
         downloading_o <= 1'b0;
      end else begin
         case (state_q)
            romload_pkg::WR_IDLE: begin
               if (pop_o) begin
                  case (pop_item_i.kind)
                     romload_pkg::KIND_START: begin
                        downloading_o <= 1'b1;
                        ioctl_addr_o  <= '0;   // new image from zero
                     end
                     romload_pkg::KIND_END: begin
                        downloading_o <= 1'b0;
                     end
                     romload_pkg::KIND_DATA: begin
                        // stray bytes outside a download are dropped
                        if (downloading_o) begin
                           ioctl_req_o <= 1'b1;
                           state_q     <= romload_pkg::WR_REQ;
                        end
                     end
                     default: state_q <= romload_pkg::WR_IDLE;
                  endcase
               end
            end

            romload_pkg::WR_REQ: begin
               if (ioctl_ack_i) begin
                  ioctl_req_o <= 1'b0;
                  state_q     <= romload_pkg::WR_RELEASE;
               end
            end

            romload_pkg::WR_RELEASE: begin
               // both low here, safe to move the address
               if (!ioctl_ack_i) begin
                  ioctl_addr_o <= ioctl_addr_o + 1'b1;   // wraps at 2^AW
                  state_q      <= romload_pkg::WR_IDLE;
               end
            end

            default: begin
               ioctl_req_o <= 1'b0;
               state_q     <= romload_pkg::WR_IDLE;
            end
         endcase
      end
   end

   // byte latched at pop, held through the handshake
   always_ff @(posedge clk_sys) begin
      if (pop_o && pop_item_i.kind == romload_pkg::KIND_DATA) begin
         ioctl_data_o <= pop_item_i.data;
      end
   end

endmodule

// ==== rtl/romload_pkg.sv ====
// **********************************************************
// shared types for the SPI ROM download path
// frame opcodes, FIFO item layout and writer FSM states
// **********************************************************

package romload_pkg;

   // command byte that opens each SPI frame
   typedef enum logic [7:0] {
      OP_START = 8'h53,
      OP_DATA  = 8'h54,
      OP_END   = 8'h55
   } dl_op_e;

   // what a buffered item asks the writer to do
   typedef enum logic [1:0] {
      KIND_START = 2'd0,
      KIND_DATA  = 2'd1,
      KIND_END   = 2'd2
   } dl_kind_e;

   // one FIFO entry, 10 bits
   typedef struct packed {
      dl_kind_e   kind;
      logic [7:0] data;    // only valid for KIND_DATA
   } dl_item_t;

   // memory writer FSM
   typedef enum logic [1:0] {
      WR_IDLE    = 2'd0,   // free to pop
      WR_REQ     = 2'd1,   // req high, waiting for ack
      WR_RELEASE = 2'd2    // req low, waiting for ack to drop
   } wr_state_e;

endpackage

// ==== rtl/romload_top.sv ====
// **********************************************************
// ROM download path: SPI receiver, item FIFO, memory writer
// set AW and FIFO_DEPTH here, everything runs on clk_sys
// **********************************************************

`timescale 1ns/10ps

module romload_top #(
   parameter int AW         = 22,
   parameter int FIFO_DEPTH = 8
) (
   input  logic          clk_sys,
   input  logic          rst_i,
   input  logic          spi_sck_i,
   input  logic          spi_ss_i,
   input  logic          spi_di_i,
   input  logic          ioctl_ack_i,
   output logic [AW-1:0] ioctl_addr_o,
   output logic [7:0]    ioctl_data_o,
   output logic          ioctl_req_o,
   output logic          downloading_o,
   output logic          overflow_o
);

   logic                  push;
   romload_pkg::dl_item_t push_item;
   logic                  pop;
   romload_pkg::dl_item_t pop_item;
   logic                  empty;

   spi_cmd_rx spi_cmd_rx_inst (
      .clk_sys     ( clk_sys     ),
      .rst_i       ( rst_i       ),
      .spi_sck_i   ( spi_sck_i   ),
      .spi_ss_i    ( spi_ss_i    ),
      .spi_di_i    ( spi_di_i    ),
      .push_o      ( push        ),
      .push_item_o ( push_item   )
   );

   dl_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) dl_fifo_inst (
      .clk_sys     ( clk_sys     ),
      .rst_i       ( rst_i       ),
      .push_i      ( push        ),
      .push_item_i ( push_item   ),
      .pop_i       ( pop         ),
      .pop_item_o  ( pop_item    ),
      .empty_o     ( empty       ),
      .overflow_o  ( overflow_o  )
   );

   ioctl_writer #(.AW(AW)) ioctl_writer_inst (
      .clk_sys       ( clk_sys       ),
      .rst_i         ( rst_i         ),
      .empty_i       ( empty         ),
      .pop_item_i    ( pop_item      ),
      .ioctl_ack_i   ( ioctl_ack_i   ),
      .pop_o         ( pop           ),
      .ioctl_addr_o  ( ioctl_addr_o  ),
      .ioctl_data_o  ( ioctl_data_o  ),
      .ioctl_req_o   ( ioctl_req_o   ),
      .downloading_o ( downloading_o )
   );

endmodule

// ==== rtl/spi_cmd_rx.sv ====
// **********************************************************
// SPI frame receiver oversampled on clk_sys
// turns command frames into download items for the FIFO
// **********************************************************

`timescale 1ns/10ps

module spi_cmd_rx (
   input  logic                  clk_sys,
   input  logic                  rst_i,
   input  logic                  spi_sck_i,
   input  logic                  spi_ss_i,      // active low
   input  logic                  spi_di_i,
   output logic                  push_o,
   output romload_pkg::dl_item_t push_item_o
);

   // two-flop synchronizers
   logic sck_meta_q;
   logic sck_sync_q;
   logic sck_last_q;
   logic ss_meta_q;
   logic ss_sync_q;
   logic ss_last_q;
   logic di_meta_q;
   logic di_sync_q;

   // byte assembly and frame state
   logic [6:0]          shift_q;
   logic [2:0]          bit_cnt_q;
   logic                cmd_seen_q;
   romload_pkg::dl_op_e cmd_q;

   logic                  sck_rise_w;
   logic                  ss_fall_w;
   logic                  byte_done_w;
   logic [7:0]            byte_w;
   logic                  emit_w;
   romload_pkg::dl_item_t item_w;

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         sck_meta_q <= 1'b0;
         sck_sync_q <= 1'b0;
         sck_last_q <= 1'b0;
         ss_meta_q  <= 1'b1;   // deselected
         ss_sync_q  <= 1'b1;
         ss_last_q  <= 1'b1;
      end else begin
         sck_meta_q <= spi_sck_i;
         sck_sync_q <= sck_meta_q;
         sck_last_q <= sck_sync_q;
         ss_meta_q  <= spi_ss_i;
         ss_sync_q  <= ss_meta_q;
         ss_last_q  <= ss_sync_q;
      end
   end

   // data line synchronizer
   always_ff @(posedge clk_sys) begin
      di_meta_q <= spi_di_i;
      di_sync_q <= di_meta_q;
   end

   assign sck_rise_w  = sck_sync_q & ~sck_last_q & ~ss_sync_q;
   assign ss_fall_w   = ss_last_q & ~ss_sync_q;
   assign byte_w      = {shift_q, di_sync_q};   // MSB first
   assign byte_done_w = sck_rise_w && (bit_cnt_q == 3'd7);

   always_comb begin
      emit_w      = 1'b0;
      item_w.kind = romload_pkg::KIND_DATA;
      item_w.data = byte_w;
      if (byte_done_w) begin
         if (!cmd_seen_q) begin
            // first byte is the command
            case (byte_w)
               romload_pkg::OP_START: begin
                  emit_w      = 1'b1;
                  item_w.kind = romload_pkg::KIND_START;
               end
               romload_pkg::OP_END: begin
                  emit_w      = 1'b1;
                  item_w.kind = romload_pkg::KIND_END;
               end
               default: emit_w = 1'b0;
            endcase
         end else if (cmd_q == romload_pkg::OP_DATA) begin
            emit_w = 1'b1;            // payload byte
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         bit_cnt_q  <= 3'd0;
         cmd_seen_q <= 1'b0;
         cmd_q      <= romload_pkg::OP_END;
         push_o     <= 1'b0;
      end else begin
         push_o <= emit_w;
         if (ss_fall_w) begin
            bit_cnt_q  <= 3'd0;        // drops any partial byte
            cmd_seen_q <= 1'b0;
         end else if (sck_rise_w) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (byte_done_w && !cmd_seen_q) begin
               cmd_seen_q <= 1'b1;
               cmd_q      <= romload_pkg::dl_op_e'(byte_w);
            end
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (sck_rise_w) begin
         shift_q <= byte_w[6:0];
      end
      if (emit_w) begin
         push_item_o <= item_w;
      end
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the ROM download testbench with Verilator and runs it
# exit status is 0 only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_romload \
   -o tb_romload_sim || { echo "verilator build failed"; exit 1; }
sim_out=$(./obj_dir/tb_romload_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "^=== PASS ===$" && exit 0 || exit 1

// ==== tb/tb_romload_tasks.svh ====
// **********************************************************
// SPI master driver and typed compare tasks
// included inside the body of the download testbench module
// **********************************************************

// top nbits of value, msb first, data set while SCK low
task automatic spi_bits(input logic [7:0] value, input int nbits);
   for (int i = 7; i > 7 - nbits; i--) begin
      spi_di_i = value[i];
      repeat (SCK_HALF) @(negedge clk_sys);
      spi_sck_i = 1'b1;
      repeat (SCK_HALF) @(negedge clk_sys);
      spi_sck_i = 1'b0;
   end
endtask

// one SS framed transfer: command, payload_q, then optional stray bits
task automatic send_frame(input logic [7:0] cmd, input int tail_bits);
   spi_ss_i = 1'b0;
   repeat (SCK_HALF) @(negedge clk_sys);   // let the SS fall get through sync
   spi_bits(cmd, 8);
   foreach (payload_q[i]) begin
      spi_bits(payload_q[i], 8);
   end
   if (tail_bits > 0) begin
      spi_bits(8'($random(seed)), tail_bits);
   end
   repeat (SCK_HALF) @(negedge clk_sys);
   spi_ss_i = 1'b1;
   repeat (2 * SCK_HALF) @(negedge clk_sys);
endtask

task automatic check_write(input logic [AW-1:0] addr, input logic [7:0] data);
   exp_write_t exp;
   if (exp_q.size() == 0) begin
      $display("ERROR @%0t: memory write of %h to address %h when no write was expected",
               $time, data, addr);
      other_errs++;
   end else begin
      exp = exp_q.pop_front();
      if (addr !== exp.addr || data !== exp.data) begin
         $display("MISMATCH @%0t: write %h <= %h, expected %h <= %h",
                  $time, addr, data, exp.addr, exp.data);
         mismatch_errs++;
      end
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("MISMATCH @%0t: %s is %b, expected %b", $time, name, got, exp);
      mismatch_errs++;
   end
endtask

// ==== tb/tb_romload.sv ====
// **********************************************************
// testbench for the SPI ROM download path
// random frames and ack delays with writes checked against a model
// **********************************************************

`timescale 1ns/10ps

module tb_romload;

   localparam int AW         = 22;
   localparam int FIFO_DEPTH = 8;
   localparam int SCK_HALF   = 8;    // clk_sys cycles per SCK phase
   localparam int CLK_NS     = 40;

   // one expected memory write
   typedef struct packed {
      logic [AW-1:0] addr;
      logic [7:0]    data;
   } exp_write_t;

   logic          clk_sys;
   logic          rst_i;
   logic          spi_sck_i;
   logic          spi_ss_i;
   logic          spi_di_i;
   logic          ioctl_ack_i = 1'b0;
   logic [AW-1:0] ioctl_addr_o;
   logic [7:0]    ioctl_data_o;
   logic          ioctl_req_o;
   logic          downloading_o;
   logic          overflow_o;

   integer        seed = 58;
   logic [7:0]    payload_q [$];
   exp_write_t    exp_q [$];
   int            mismatch_errs = 0;
   int            other_errs = 0;

   // write model state
   logic          model_dl = 1'b0;
   logic [AW-1:0] model_addr = '0;

   // memory responder and handshake monitor
   logic          hold_ack = 1'b0;
   int            ack_wait = 0;
   int            drop_wait = 0;
   logic          req_prev = 1'b0;
   logic [AW-1:0] held_addr;
   logic [7:0]    held_data;

   int            n_restart;
   int            n_random;
   longint        watchdog_ns = 0;

   initial clk_sys = 1'b0;
   always #(CLK_NS / 2) clk_sys = ~clk_sys;

   romload_top #(.AW(AW), .FIFO_DEPTH(FIFO_DEPTH)) romload_top_inst (
      .clk_sys       ( clk_sys       ),
      .rst_i         ( rst_i         ),
      .spi_sck_i     ( spi_sck_i     ),
      .spi_ss_i      ( spi_ss_i      ),
      .spi_di_i      ( spi_di_i      ),
      .ioctl_ack_i   ( ioctl_ack_i   ),
      .ioctl_addr_o  ( ioctl_addr_o  ),
      .ioctl_data_o  ( ioctl_data_o  ),
      .ioctl_req_o   ( ioctl_req_o   ),
      .downloading_o ( downloading_o ),
      .overflow_o    ( overflow_o    )
   );

   `include "tb_romload_tasks.svh"

   // queues the expected writes of one frame, at most keep of them
   task automatic model_frame(input logic [7:0] cmd, input int keep);
      exp_write_t w;
      int         kept;
      kept = 0;
      case (cmd)
         romload_pkg::OP_START: begin
            model_dl   = 1'b1;
            model_addr = '0;
         end
         romload_pkg::OP_END: begin
            model_dl = 1'b0;
         end
         romload_pkg::OP_DATA: begin
            foreach (payload_q[i]) begin
               if (model_dl && kept < keep) begin
                  w.addr = model_addr;
                  w.data = payload_q[i];
                  exp_q.push_back(w);
                  model_addr = model_addr + 1'b1;
                  kept++;
               end
            end
         end
         default: kept = 0;   // unknown command writes nothing
      endcase
   endtask

   task automatic run_frame(input logic [7:0] cmd, input int n_bytes, input int keep,
                            input int tail_bits);
      payload_q.delete();
      repeat (n_bytes) begin
         payload_q.push_back(8'($random(seed)));
      end
      model_frame(cmd, keep);
      send_frame(cmd, tail_bits);
   endtask

   // writes done and the port quiet for a while
   task automatic wait_idle();
      int quiet;
      quiet = 0;
      while (quiet < 20) begin
         @(negedge clk_sys);
         if (exp_q.size() == 0 && !ioctl_req_o && !ioctl_ack_i) begin
            quiet++;
         end else begin
            quiet = 0;
         end
      end
   endtask

   always @(negedge clk_sys) begin
      if (rst_i) begin
         req_prev = 1'b0;
      end else begin
         // monitor sees ack as the DUT did at the last posedge
         if (ioctl_req_o && !req_prev) begin
            check_flag("ack at req rise", ioctl_ack_i, 1'b0);
            check_write(ioctl_addr_o, ioctl_data_o);
            held_addr = ioctl_addr_o;
            held_data = ioctl_data_o;
         end else if (ioctl_req_o || ioctl_ack_i) begin
            if (ioctl_addr_o !== held_addr || ioctl_data_o !== held_data) begin
               $display("MISMATCH @%0t: address or data moved during handshake", $time);
               mismatch_errs++;
            end
         end
         req_prev = ioctl_req_o;

         // responder waits 0 to 5 cycles each way
         if (!ioctl_ack_i) begin
            if (ioctl_req_o && !hold_ack) begin
               if (ack_wait == 0) begin
                  ioctl_ack_i = 1'b1;
                  drop_wait   = {$random(seed)} % 6;
               end else begin
                  ack_wait--;
               end
            end
         end else if (!ioctl_req_o) begin
            if (drop_wait == 0) begin
               ioctl_ack_i = 1'b0;
               ack_wait    = {$random(seed)} % 6;
            end else begin
               drop_wait--;
            end
         end
      end
   end

   initial begin
      romload_pkg::wr_state_e st;
      wait (watchdog_ns != 0);
      #(watchdog_ns);
      st = romload_top_inst.ioctl_writer_inst.state_q;
      $display("ERROR: timeout after %0d ns, %0d writes still expected, writer in %s",
               watchdog_ns, exp_q.size(), st.name());
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      int total_bytes;
      rst_i     = 1'b1;
      spi_sck_i = 1'b0;
      spi_ss_i  = 1'b1;
      spi_di_i  = 1'b0;
      n_restart = 5 + {$random(seed)} % 12;
      n_random  = 8 + {$random(seed)} % 17;
      // every byte on the wire including commands and the partial byte
      total_bytes = 65 + n_restart + n_random;
      watchdog_ns = longint'(total_bytes) * 8 * (2 * SCK_HALF) * CLK_NS * 2;
      repeat (2) @(negedge clk_sys);
      rst_i = 1'b0;
      @(negedge clk_sys);
      check_flag("downloading_o after reset", downloading_o, 1'b0);
      check_flag("overflow_o after reset", overflow_o, 1'b0);
      check_flag("ioctl_req_o after reset", ioctl_req_o, 1'b0);
      check_flag("address zero after reset", ioctl_addr_o == '0, 1'b1);

      // basic download of 20 bytes
      run_frame(romload_pkg::OP_START, 0, 0, 0);
      wait_idle();
      check_flag("downloading_o after START", downloading_o, 1'b1);
      run_frame(romload_pkg::OP_DATA, 20, 20, 0);
      run_frame(romload_pkg::OP_END, 0, 0, 0);
      wait_idle();
      check_flag("downloading_o after END", downloading_o, 1'b0);

      // second download restarts at zero
      run_frame(romload_pkg::OP_START, 0, 0, 0);
      wait_idle();
      check_flag("downloading_o after restart", downloading_o, 1'b1);
      run_frame(romload_pkg::OP_DATA, n_restart, n_restart, 0);
      run_frame(romload_pkg::OP_END, 0, 0, 0);
      wait_idle();
      check_flag("downloading_o after second END", downloading_o, 1'b0);

      // frames with nothing to write and then a cut off frame
      run_frame(romload_pkg::OP_DATA, 4, 4, 0);
      run_frame(8'h42, 4, 4, 0);
      wait_idle();
      run_frame(romload_pkg::OP_START, 0, 0, 0);
      run_frame(romload_pkg::OP_DATA, 5, 5, 3);   // 3 stray bits dropped
      run_frame(romload_pkg::OP_END, 0, 0, 0);
      wait_idle();

      // longer random download with the handshake watched by the monitor
      run_frame(romload_pkg::OP_START, 0, 0, 0);
      run_frame(romload_pkg::OP_DATA, n_random, n_random, 0);
      run_frame(romload_pkg::OP_END, 0, 0, 0);
      wait_idle();

      // stalled memory holds one item in flight plus a full FIFO
      run_frame(romload_pkg::OP_START, 0, 0, 0);
      wait_idle();
      hold_ack = 1'b1;
      run_frame(romload_pkg::OP_DATA, 12, FIFO_DEPTH + 1, 0);
      check_flag("overflow_o while stalled", overflow_o, 1'b1);
      hold_ack = 1'b0;
      wait_idle();
      check_flag("overflow_o after drain", overflow_o, 1'b1);
      run_frame(romload_pkg::OP_END, 0, 0, 0);
      wait_idle();
      check_flag("downloading_o after overflow END", downloading_o, 1'b0);
      check_flag("overflow_o after END", overflow_o, 1'b1);
      run_frame(romload_pkg::OP_START, 0, 0, 0);
      wait_idle();
      check_flag("overflow_o after next START", overflow_o, 1'b0);
      run_frame(romload_pkg::OP_END, 0, 0, 0);
      wait_idle();

      $display("summary: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
      if (mismatch_errs == 0 && other_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
